// File: common/l1d_if.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

interface l1d_if ();

   logic                  req;
   logic                  we;      // Store when set, load otherwise.
   logic [`L1D_IDX_W-1:0] idx;
   logic [`XLEN-1:0]      wdata;
   logic [`XLEN-1:0]      rdata;   // Valid the cycle after a read.

   modport master (
      output req, we, idx, wdata,
      input  rdata
   );

   modport slave (
      input  req, we, idx, wdata,
      output rdata
   );

endinterface

// File: common/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ##########################################################################
// Cluster sizes
// ##########################################################################

`define DISP_SIZE    4   // Slots per dispatch group.
`define MEM_Q_SIZE   4   // Memory queue entries.
`define MEM_Q_IDX_W  2   // Queue index width.

// ##########################################################################
// Datapath and L1D geometry
// ##########################################################################

`define XLEN         32  // Data and address width.
`define RD_W         6   // Destination tag width.
`define L1D_WORDS    64  // Words in the data array.
`define L1D_IDX_W    6   // Word index width.

`endif

// File: common/lsu_issue_if.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

interface lsu_issue_if import lsu_pkg::*; ();

   logic                    issue_valid;   // One-cycle pulse.
   disp_t                   issue_inst;
   logic [`MEM_Q_IDX_W-1:0] issue_index;

   logic                    done_valid;    // Pulsed at EX3.
   logic [`MEM_Q_IDX_W-1:0] done_index;

   modport sched (
      output issue_valid, issue_inst, issue_index,
      input  done_valid, done_index
   );

   modport pipe (
      input  issue_valid, issue_inst, issue_index,
      output done_valid, done_index
   );

endinterface

// File: common/lsu_pkg.sv
`include "lsu_consts.svh"

package lsu_pkg;

   // ##########################################################################
   // Instruction encoding
   // ##########################################################################

   typedef enum logic {
      MEM_LOAD  = 1'b0,   // Word load.
      MEM_STORE = 1'b1    // Word store.
   } mem_op_e;

   // One dispatched memory instruction, operands already read.
   typedef struct packed {
      mem_op_e          op;
      logic [`XLEN-1:0] base;
      logic [`XLEN-1:0] offset;
      logic [`XLEN-1:0] sdata;    // Only meaningful for stores.
      logic [`RD_W-1:0] rd;       // Only meaningful for loads.
   } disp_t;

   // ##########################################################################
   // Memory queue
   // ##########################################################################

   typedef enum logic [1:0] {
      ENT_FREE   = 2'd0,
      ENT_WAIT   = 2'd1,   // Holding, not yet sent to the pipe.
      ENT_ISSUED = 2'd2    // In the pipe, waiting for done.
   } entry_state_e;

   // Word index into the L1D. Sub-word bits are dropped, upper bits wrap.
   function automatic logic [`L1D_IDX_W-1:0] l1d_word_idx(
      input logic [`XLEN-1:0] addr
   );
      return addr[2 +: `L1D_IDX_W];
   endfunction

endpackage

// File: hw/lsu/lsu_disp_pick.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_disp_pick import lsu_pkg::*; #(
   parameter int NUM = 0
) (
   input  logic [`DISP_SIZE-1:0] i_valids,
   input  disp_t                 i_data [`DISP_SIZE],
   output logic                  o_valid,
   output disp_t                 o_data
);

   // ##########################################################################
   // Rank search over the group
   // ##########################################################################

   // Slot order is program order, so the n-th set bit is the n-th instruction.
   logic [`DISP_SIZE-1:0] w_sel;

   always_comb begin
      int unsigned cnt;

      cnt   = 0;
      w_sel = '0;
      for (int i = 0; i < `DISP_SIZE; i++) begin
         if (i_valids[i]) begin
            if (cnt == NUM) begin
               w_sel[i] = 1'b1;
            end
            cnt = cnt + 1;
         end
      end
   end

   // One-hot mux of the selected slot.
   always_comb begin
      o_data = '0;
      for (int i = 0; i < `DISP_SIZE; i++) begin
         if (w_sel[i]) begin
            o_data = i_data[i];
         end
      end
   end

   assign o_valid = |w_sel;   // No such slot in this group.

endmodule

// File: hw/lsu/lsu_l1d.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_l1d (
   input logic  i_clk,
   l1d_if.slave l1d
);

   // ##########################################################################
   // Data array
   // ##########################################################################

   logic [`XLEN-1:0] r_mem [`L1D_WORDS];
   logic [`XLEN-1:0] r_rdata;

   always_ff @(posedge i_clk) begin
      if (l1d.req && l1d.we) begin
         r_mem[l1d.idx] <= l1d.wdata;
      end
   end

   // Read data held until the next read.
   always_ff @(posedge i_clk) begin
      if (l1d.req && !l1d.we) begin
         r_rdata <= r_mem[l1d.idx];
      end
   end

   assign l1d.rdata = r_rdata;

endmodule

// File: hw/lsu/lsu_pipe.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_pipe import lsu_pkg::*; (
   input  logic             i_clk,
   input  logic             i_reset,
   lsu_issue_if.pipe        issue,
   l1d_if.master            l1d,
   output logic             o_wb_valid,
   output logic [`RD_W-1:0] o_wb_rd,
   output logic [`XLEN-1:0] o_wb_data
);

   localparam int IDX_W = `MEM_Q_IDX_W;

   // ##########################################################################
   // EX1 address generation
   // ##########################################################################

   logic             r_ex1_valid;
   disp_t            r_ex1_inst;
   logic [IDX_W-1:0] r_ex1_index;
   logic [`XLEN-1:0] w_ex1_addr;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_ex1_valid <= 1'b0;
      end else begin
         r_ex1_valid <= issue.issue_valid;
      end
      r_ex1_inst  <= issue.issue_inst;
      r_ex1_index <= issue.issue_index;
   end

   assign w_ex1_addr = r_ex1_inst.base + r_ex1_inst.offset;

   // ##########################################################################
   // EX2 L1D access
   // ##########################################################################

   logic                  r_ex2_valid;
   mem_op_e               r_ex2_op;
   logic [`L1D_IDX_W-1:0] r_ex2_idx;
   logic [`XLEN-1:0]      r_ex2_sdata;
   logic [`RD_W-1:0]      r_ex2_rd;
   logic [IDX_W-1:0]      r_ex2_index;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_ex2_valid <= 1'b0;
      end else begin
         r_ex2_valid <= r_ex1_valid;
      end
      r_ex2_op    <= r_ex1_inst.op;
      r_ex2_idx   <= l1d_word_idx(w_ex1_addr);
      r_ex2_sdata <= r_ex1_inst.sdata;
      r_ex2_rd    <= r_ex1_inst.rd;
      r_ex2_index <= r_ex1_index;
   end

   assign l1d.req   = r_ex2_valid;
   assign l1d.we    = (r_ex2_op == MEM_STORE);   // Store lands at this edge.
   assign l1d.idx   = r_ex2_idx;
   assign l1d.wdata = r_ex2_sdata;

   // ##########################################################################
   // EX3 writeback and done
   // ##########################################################################

   logic             r_ex3_valid;
   mem_op_e          r_ex3_op;
   logic [`RD_W-1:0] r_ex3_rd;
   logic [IDX_W-1:0] r_ex3_index;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_ex3_valid <= 1'b0;
      end else begin
         r_ex3_valid <= r_ex2_valid;
      end
      r_ex3_op    <= r_ex2_op;
      r_ex3_rd    <= r_ex2_rd;
      r_ex3_index <= r_ex2_index;
   end

   assign issue.done_valid = r_ex3_valid;
   assign issue.done_index = r_ex3_index;

   assign o_wb_valid = r_ex3_valid && (r_ex3_op == MEM_LOAD);
   assign o_wb_rd    = r_ex3_rd;
   assign o_wb_data  = l1d.rdata;   // Registered read from EX2.

   // An entry is in the pipe at most once.
   a_issue_unique: assert property (@(posedge i_clk) disable iff (i_reset)
      issue.issue_valid |-> !(r_ex1_valid && r_ex1_index == issue.issue_index)
                            && !(r_ex2_valid && r_ex2_index == issue.issue_index)
                            && !(r_ex3_valid && r_ex3_index == issue.issue_index));

endmodule

// File: hw/lsu/lsu_scheduler.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_scheduler import lsu_pkg::*; (
   input  logic        i_clk,
   input  logic        i_reset,
   input  logic [1:0]  i_disp_valid,
   input  disp_t       i_disp_inst [2],
   output logic        o_disp_ready,
   lsu_issue_if.sched  issue
);

   localparam int IDX_W = `MEM_Q_IDX_W;

   entry_state_e     r_state [`MEM_Q_SIZE];
   disp_t            r_inst  [`MEM_Q_SIZE];
   logic [IDX_W-1:0] r_age   [`MEM_Q_SIZE];   // Younger entries seen.

   logic [1:0]       w_accept;
   logic [IDX_W-1:0] w_num_acc;
   logic [IDX_W-1:0] w_alloc_idx [2];
   logic [1:0]       w_alloc_ok;
   logic [IDX_W:0]   w_free_cnt;

   logic             w_iss_valid;
   logic [IDX_W-1:0] w_iss_idx;
   logic [IDX_W-1:0] w_iss_age;

   // ##########################################################################
   // Allocation
   // ##########################################################################

   always_comb begin
      w_free_cnt     = '0;
      w_alloc_ok     = '0;
      w_alloc_idx[0] = '0;
      w_alloc_idx[1] = '0;
      for (int i = 0; i < `MEM_Q_SIZE; i++) begin
         if (r_state[i] == ENT_FREE) begin
            if (!w_alloc_ok[0]) begin
               w_alloc_idx[0] = IDX_W'(i);
               w_alloc_ok[0]  = 1'b1;
            end else if (!w_alloc_ok[1]) begin
               w_alloc_idx[1] = IDX_W'(i);
               w_alloc_ok[1]  = 1'b1;
            end
            w_free_cnt = w_free_cnt + 1'b1;
         end
      end
   end

   assign o_disp_ready = (w_free_cnt >= 2);   // Room for a full group.
   assign w_accept     = i_disp_valid & {2{o_disp_ready}};
   assign w_num_acc    = IDX_W'(w_accept[0]) + IDX_W'(w_accept[1]);

   // ##########################################################################
   // Oldest-first issue
   // ##########################################################################

   always_comb begin
      w_iss_valid = 1'b0;
      w_iss_idx   = '0;
      w_iss_age   = '0;
      for (int i = 0; i < `MEM_Q_SIZE; i++) begin
         if (r_state[i] == ENT_WAIT && (!w_iss_valid || r_age[i] > w_iss_age)) begin
            w_iss_valid = 1'b1;
            w_iss_idx   = IDX_W'(i);
            w_iss_age   = r_age[i];
         end
      end
   end

   assign issue.issue_valid = w_iss_valid;
   assign issue.issue_index = w_iss_idx;
   assign issue.issue_inst  = r_inst[w_iss_idx];

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         for (int i = 0; i < `MEM_Q_SIZE; i++) begin
            r_state[i] <= ENT_FREE;
            r_age[i]   <= '0;
         end
      end else begin
         for (int i = 0; i < `MEM_Q_SIZE; i++) begin
            if (issue.done_valid && issue.done_index == IDX_W'(i)) begin
               r_state[i] <= ENT_FREE;
            end else if (w_iss_valid && w_iss_idx == IDX_W'(i)) begin
               r_state[i] <= ENT_ISSUED;
            end
            if (r_state[i] != ENT_FREE) begin
               r_age[i] <= r_age[i] + w_num_acc;
            end
         end
         // First pick is older than the second.
         for (int p = 0; p < 2; p++) begin
            if (w_accept[p]) begin
               r_state[w_alloc_idx[p]] <= ENT_WAIT;
               r_age[w_alloc_idx[p]]   <= (p == 0) ? IDX_W'(w_accept[1]) : '0;
            end
         end
      end
   end

   always_ff @(posedge i_clk) begin
      for (int p = 0; p < 2; p++) begin
         if (w_accept[p]) begin
            r_inst[w_alloc_idx[p]] <= i_disp_inst[p];
         end
      end
   end

   // ##########################################################################
   // Checks
   // ##########################################################################

   // Each accepted instruction takes a free entry of its own.
   a_alloc_free: assert property (@(posedge i_clk) disable iff (i_reset)
      !$past(i_reset) |-> w_free_cnt == $past(w_free_cnt) - (IDX_W+1)'($past(w_num_acc))
                                       + (IDX_W+1)'($past(issue.done_valid)));

   a_done_issued: assert property (@(posedge i_clk) disable iff (i_reset)
      issue.done_valid |-> r_state[issue.done_index] == ENT_ISSUED);

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_top import lsu_pkg::*; (
   input  logic                              i_clk,
   input  logic                              i_reset,

   input  logic [`DISP_SIZE-1:0]             i_disp_valid,
   input  logic [`DISP_SIZE-1:0]             i_disp_op,      // Set for a store.
   input  logic [`DISP_SIZE-1:0][`XLEN-1:0]  i_disp_base,
   input  logic [`DISP_SIZE-1:0][`XLEN-1:0]  i_disp_offset,
   input  logic [`DISP_SIZE-1:0][`XLEN-1:0]  i_disp_sdata,
   input  logic [`DISP_SIZE-1:0][`RD_W-1:0]  i_disp_rd,
   output logic                              o_disp_ready,

   output logic                              o_wb_valid,
   output logic [`RD_W-1:0]                  o_wb_rd,
   output logic [`XLEN-1:0]                  o_wb_data
);

   disp_t      w_disp_inst [`DISP_SIZE];
   disp_t      w_picked_inst [2];
   logic [1:0] w_picked_valid;

   lsu_issue_if issue_bus ();
   l1d_if       l1d_bus ();

   // ##########################################################################
   // Dispatch packing and pick
   // ##########################################################################

   for (genvar d_idx = 0; d_idx < `DISP_SIZE; d_idx++) begin : g_disp
      assign w_disp_inst[d_idx].op     = mem_op_e'(i_disp_op[d_idx]);
      assign w_disp_inst[d_idx].base   = i_disp_base[d_idx];
      assign w_disp_inst[d_idx].offset = i_disp_offset[d_idx];
      assign w_disp_inst[d_idx].sdata  = i_disp_sdata[d_idx];
      assign w_disp_inst[d_idx].rd     = i_disp_rd[d_idx];
   end

   for (genvar p_idx = 0; p_idx < 2; p_idx++) begin : g_pick
      lsu_disp_pick #(.NUM(p_idx)) u_disp_pick (
         .i_valids (i_disp_valid),
         .i_data   (w_disp_inst),
         .o_valid  (w_picked_valid[p_idx]),
         .o_data   (w_picked_inst[p_idx])
      );
   end

   // ##########################################################################
   // Queue, pipe and L1D
   // ##########################################################################

   lsu_scheduler u_scheduler (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_disp_valid (w_picked_valid),
      .i_disp_inst  (w_picked_inst),
      .o_disp_ready (o_disp_ready),
      .issue        (issue_bus.sched)
   );

   lsu_pipe u_pipe (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .issue      (issue_bus.pipe),
      .l1d        (l1d_bus.master),
      .o_wb_valid (o_wb_valid),
      .o_wb_rd    (o_wb_rd),
      .o_wb_data  (o_wb_data)
   );

   lsu_l1d u_l1d (
      .i_clk (i_clk),
      .l1d   (l1d_bus.slave)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log for the result.
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
   -f sources.f --top-module tb_lsu_top -o tb_lsu_top \
   || { echo "FAIL: build error"; exit 1; }
./obj_dir/tb_lsu_top 2>&1 | tee sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/tb_lsu_top.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module tb_lsu_top import lsu_pkg::*; ();

   localparam int HALF_PERIOD  = 50;
   localparam int N_INSTR      = 728;   // All four traffic phases.
   localparam int WATCHDOG_NS  = N_INSTR * 20 * 2 * HALF_PERIOD;
   localparam int DRAIN_CYCLES = 40;    // Longest wait for the loads in flight.

   logic                             i_clk;
   logic                             i_reset;
   logic [`DISP_SIZE-1:0]            i_disp_valid;
   logic [`DISP_SIZE-1:0]            i_disp_op;
   logic [`DISP_SIZE-1:0][`XLEN-1:0] i_disp_base;
   logic [`DISP_SIZE-1:0][`XLEN-1:0] i_disp_offset;
   logic [`DISP_SIZE-1:0][`XLEN-1:0] i_disp_sdata;
   logic [`DISP_SIZE-1:0][`RD_W-1:0] i_disp_rd;
   logic                             o_disp_ready;
   logic                             o_wb_valid;
   logic [`RD_W-1:0]                 o_wb_rd;
   logic [`XLEN-1:0]                 o_wb_data;

   logic [31:0]      seed = 32'h150edcca;
   disp_t            grp [`DISP_SIZE];     // Group being offered.
   logic [`XLEN-1:0] mem_model [`L1D_WORDS];
   logic [`RD_W-1:0] exp_rd_q [$];
   logic [`XLEN-1:0] exp_data_q [$];
   int               loads_sent = 0;
   int               wb_count   = 0;
   string            test_name  = "reset";

   lsu_top lsu_top_i (.*);

   always #(HALF_PERIOD) i_clk = ~i_clk;

   // ##########################################################################
   // Random source and checks
   // ##########################################################################

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // Uses the upper bits because the low LCG bits repeat quickly.
   function automatic int rand_below(input int n);
      return int'(lcg_next() >> 8) % n;
   endfunction

   task automatic check_wb(input string name, input logic [`RD_W-1:0] exp_rd,
                           input logic [`RD_W-1:0] act_rd, input logic [`XLEN-1:0] exp_data,
                           input logic [`XLEN-1:0] act_data);
      if (exp_rd !== act_rd || exp_data !== act_data) begin
         $display("error %s: expected rd %0d data %h, actual rd %0d data %h",
                  name, exp_rd, exp_data, act_rd, act_data);
         $display("Some tests failed");
         $fatal(1);
      end
   endtask

   task automatic check_count(input string name, input int exp_cnt, input int act_cnt);
      if (exp_cnt != act_cnt) begin
         $display("error %s: expected %0d writebacks, actual %0d", name, exp_cnt, act_cnt);
         $display("Some tests failed");
         $fatal(1);
      end
   endtask

   task automatic check_flag(input string name, input logic exp_bit, input logic act_bit);
      if (exp_bit !== act_bit) begin
         $display("error %s: expected %b, actual %b", name, exp_bit, act_bit);
         $display("Some tests failed");
         $fatal(1);
      end
   endtask

   // ##########################################################################
   // Stimulus and model
   // ##########################################################################

   // Base is chosen so that base plus offset lands on the given word.
   task automatic make_inst(input int slot, input mem_op_e op, input int word);
      logic [31:0]      r;
      logic [31:0]      rd_bits;
      logic [`XLEN-1:0] offset;

      r       = lcg_next();
      offset  = lcg_next();
      rd_bits = lcg_next();
      grp[slot].op     = op;
      grp[slot].offset = offset;
      grp[slot].base   = {r[`XLEN-1:`L1D_IDX_W+2], word[`L1D_IDX_W-1:0], r[1:0]} - offset;
      grp[slot].sdata  = lcg_next();
      grp[slot].rd     = rd_bits[`RD_W-1:0];
   endtask

   task automatic fill_random_group();
      logic [31:0] r;

      for (int s = 0; s < `DISP_SIZE; s++) begin
         r = lcg_next();
         make_inst(s, mem_op_e'(r[20]), rand_below(`L1D_WORDS));
      end
   endtask

   // In-order model of one accepted group.
   task automatic apply_group(input logic [`DISP_SIZE-1:0] valids);
      logic [`XLEN-1:0] addr;

      for (int s = 0; s < `DISP_SIZE; s++) begin
         if (valids[s]) begin
            addr = grp[s].base + grp[s].offset;
            if (grp[s].op == MEM_STORE) begin
               mem_model[addr[`L1D_IDX_W+1:2]] = grp[s].sdata;
            end else begin
               exp_rd_q.push_back(grp[s].rd);
               exp_data_q.push_back(mem_model[addr[`L1D_IDX_W+1:2]]);
               loads_sent++;
            end
         end
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge i_clk);
         #1;
      end
   endtask

   // Entered 1 ns after a rising edge; the group is held until ready.
   task automatic send_group(input logic [`DISP_SIZE-1:0] valids);
      bit accepted;

      accepted = 1'b0;
      for (int s = 0; s < `DISP_SIZE; s++) begin
         i_disp_op[s]     = grp[s].op;
         i_disp_base[s]   = grp[s].base;
         i_disp_offset[s] = grp[s].offset;
         i_disp_sdata[s]  = grp[s].sdata;
         i_disp_rd[s]     = grp[s].rd;
      end
      i_disp_valid = valids;
      while (!accepted) begin
         @(negedge i_clk);
         if (o_disp_ready) begin
            apply_group(valids);
            accepted = 1'b1;
         end
         @(posedge i_clk);
         #1;
      end
      i_disp_valid = '0;
   endtask

   task automatic send_one(input mem_op_e op, input int word);
      int                    slot;
      logic [`DISP_SIZE-1:0] valids;

      fill_random_group();
      slot = rand_below(`DISP_SIZE);
      make_inst(slot, op, word);
      valids = '0;
      valids[slot] = 1'b1;
      send_group(valids);
   endtask

   task automatic drain();
      int waited;

      waited = 0;
      while (exp_rd_q.size() != 0 && waited < DRAIN_CYCLES) begin
         @(posedge i_clk);
         waited++;
      end
      idle_cycles(8);
   endtask

   // ##########################################################################
   // Writeback monitor and watchdog
   // ##########################################################################

   always @(negedge i_clk) begin
      if (!i_reset && o_wb_valid === 1'b1) begin
         if (exp_rd_q.size() == 0) begin
            $display("writeback to rd %0d in test %s came with no load outstanding",
                     o_wb_rd, test_name);
            $display("Some tests failed");
            $fatal(1);
         end else begin
            check_wb(test_name, exp_rd_q.pop_front(), o_wb_rd, exp_data_q.pop_front(),
                     o_wb_data);
            wb_count++;
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Some tests failed");
      $fatal(1);
   end

   // ##########################################################################
   // Test sequence
   // ##########################################################################

   initial begin
      int                    word;
      int                    lo;
      int                    hi;
      int                    last_store;
      logic [`DISP_SIZE-1:0] valids;

      i_clk         = 1'b0;
      i_reset       = 1'b1;
      i_disp_valid  = '0;
      i_disp_op     = '0;
      i_disp_base   = '0;
      i_disp_offset = '0;
      i_disp_sdata  = '0;
      i_disp_rd     = '0;
      repeat (3) @(posedge i_clk);
      #1;
      i_reset = 1'b0;
      @(negedge i_clk);
      check_flag("reset wb_valid", 1'b0, o_wb_valid);
      check_flag("reset disp_ready", 1'b1, o_disp_ready);
      @(posedge i_clk);
      #1;

      test_name = "init";
      for (int w = 0; w < `L1D_WORDS; w++) begin
         send_one(MEM_STORE, w);
      end
      for (int w = 0; w < `L1D_WORDS; w++) begin
         send_one(MEM_LOAD, w);
      end
      drain();

      test_name  = "single";
      last_store = 0;
      for (int n = 0; n < 200; n++) begin
         word = (rand_below(4) == 0) ? last_store : rand_below(`L1D_WORDS);
         if (rand_below(2) == 0) begin
            send_one(MEM_STORE, word);
            last_store = word;
         end else begin
            send_one(MEM_LOAD, word);
         end
         idle_cycles(rand_below(3));
      end
      drain();

      test_name = "dual";
      for (int n = 0; n < 100; n++) begin
         fill_random_group();
         lo = rand_below(`DISP_SIZE);
         hi = rand_below(`DISP_SIZE - 1);
         if (hi >= lo) begin
            hi = hi + 1;
         end else begin
            word = lo;
            lo   = hi;
            hi   = word;
         end
         if (rand_below(3) == 0) begin   // Store then reload in one group.
            word = rand_below(`L1D_WORDS);
            make_inst(lo, MEM_STORE, word);
            make_inst(hi, MEM_LOAD, word);
         end
         valids     = '0;
         valids[lo] = 1'b1;
         valids[hi] = 1'b1;
         send_group(valids);
         idle_cycles(rand_below(2));
      end
      drain();

      test_name = "backpressure";
      for (int n = 0; n < 100; n++) begin
         fill_random_group();
         valids = '0;
         valids[rand_below(`DISP_SIZE)] = 1'b1;
         if (rand_below(2) == 0) begin
            valids[rand_below(`DISP_SIZE)] = 1'b1;
         end
         send_group(valids);
      end
      drain();
      check_count("writeback count", loads_sent, wb_count);

      $display("All tests passed");
      $finish;
   end

endmodule

// File: sources.f
+incdir+common
common/lsu_pkg.sv
common/lsu_issue_if.sv
common/l1d_if.sv
hw/lsu/lsu_disp_pick.sv
hw/lsu/lsu_scheduler.sv
hw/lsu/lsu_pipe.sv
hw/lsu/lsu_l1d.sv
hw/lsu_top.sv
sim/tb_lsu_top.sv
